// File: common/axi_sram_pkg.sv
package axi_sram_pkg;

  ////////////////////////////////////////
  // widths.
  ////////////////////////////////////////

  localparam int AXI_ADDR_WIDTH = 12;   // byte address.
  localparam int AXI_DATA_WIDTH = 16;
  localparam int ID_WIDTH       = 4;
  localparam int STRB_WIDTH     = AXI_DATA_WIDTH / 8;
  localparam int ADDR_LSB       = $clog2(STRB_WIDTH);  // byte offset bits.
  localparam int SRAM_ADDR_WIDTH = AXI_ADDR_WIDTH - ADDR_LSB;
  localparam int SRAM_DEPTH     = 2 ** SRAM_ADDR_WIDTH;

  ////////////////////////////////////////
  // encodings.
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    burst_fixed = 2'b00,
    burst_incr  = 2'b01,
    burst_wrap  = 2'b10   // not supported.
  } axi_burst_e;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axi_resp_e;

  ////////////////////////////////////////
  // channel payloads.
  ////////////////////////////////////////

  // address channel, shared by ar and aw.
  typedef struct packed {
    logic [ID_WIDTH-1:0]       id;
    logic [AXI_ADDR_WIDTH-1:0] addr;
    logic [7:0]                len;
    axi_burst_e                burst;
  } axi_ar_t;

  typedef struct packed {
    logic [AXI_DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0]     strb;
    logic                      last;
  } axi_w_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0]       id;
    logic [AXI_DATA_WIDTH-1:0] data;
    axi_resp_e                 resp;
    logic                      last;
  } axi_r_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0] id;
    axi_resp_e           resp;
  } axi_b_t;

  // sram side, meta carries the axi id through.
  typedef struct packed {
    logic [SRAM_ADDR_WIDTH-1:0] addr;
    logic                       wr_en;
    logic [AXI_DATA_WIDTH-1:0]  data;
    logic [STRB_WIDTH-1:0]      strb;
    logic [ID_WIDTH-1:0]        meta;
    logic                       last;
  } sram_cmd_t;

  typedef struct packed {
    logic [AXI_DATA_WIDTH-1:0] data;
    logic [ID_WIDTH-1:0]       meta;
    logic                      last;
  } sram_rsp_t;

endpackage

// File: rtl/sram_mem.sv
`timescale 1ns/10ps

module sram_mem (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cmd_valid,
  output logic                    cmd_ready,
  input  axi_sram_pkg::sram_cmd_t cmd,
  output logic                    rsp_valid,
  input  logic                    rsp_ready,
  output axi_sram_pkg::sram_rsp_t rsp
);

  logic [axi_sram_pkg::AXI_DATA_WIDTH-1:0] mem [axi_sram_pkg::SRAM_DEPTH];
  logic                                    cmd_fire;

  // stall while the response register can't be emptied.
  assign cmd_ready = !rsp_valid || rsp_ready;
  assign cmd_fire  = cmd_valid && cmd_ready;

  always_ff @(posedge clk) begin
    if (cmd_fire && cmd.wr_en) begin
      for (int i = 0; i < axi_sram_pkg::STRB_WIDTH; i++) begin
        if (cmd.strb[i]) mem[cmd.addr][i*8 +: 8] <= cmd.data[i*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (~rst_n) begin
      rsp_valid <= 1'b0;
    end else if (cmd_fire && !cmd.wr_en) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_fire && !cmd.wr_en) begin
      rsp.data <= mem[cmd.addr];
      rsp.meta <= cmd.meta;  // id rides along.
      rsp.last <= cmd.last;
    end
  end

endmodule

// File: axi_sram/axi_sram_rd.sv
`timescale 1ns/10ps

module axi_sram_rd (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    ar_valid,
  output logic                    ar_ready,
  input  axi_sram_pkg::axi_ar_t   ar,
  output logic                    r_valid,
  input  logic                    r_ready,
  output axi_sram_pkg::axi_r_t    r,
  output logic                    cmd_valid,
  input  logic                    cmd_ready,
  output axi_sram_pkg::sram_cmd_t cmd,
  input  logic                    rsp_valid,
  output logic                    rsp_ready,
  input  axi_sram_pkg::sram_rsp_t rsp
);

  logic                                     busy;
  logic [7:0]                               beats_left;
  logic [axi_sram_pkg::SRAM_ADDR_WIDTH-1:0] word_addr;
  logic [axi_sram_pkg::ID_WIDTH-1:0]        id;
  axi_sram_pkg::axi_burst_e                 burst;
  logic                                     ar_fire;
  logic                                     cmd_fire;

  assign ar_ready = ~busy;  // one burst in conversion.
  assign ar_fire  = ar_valid && ar_ready;
  assign cmd_fire = cmd_valid && cmd_ready;

  ////////////////////////////////////////
  // ar to read commands.
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (~rst_n) begin
      busy <= 1'b0;
    end else if (ar_fire) begin
      busy <= 1'b1;
    end else if (cmd_fire && beats_left == 8'd0) begin
      busy <= 1'b0;  // final beat issued.
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      beats_left <= ar.len;
      word_addr  <= ar.addr[axi_sram_pkg::AXI_ADDR_WIDTH-1:axi_sram_pkg::ADDR_LSB];
      id         <= ar.id;
      burst      <= ar.burst;
    end else if (cmd_fire) begin
      beats_left <= beats_left - 8'd1;
      // fixed bursts keep hitting the same word.
      if (burst == axi_sram_pkg::burst_incr) begin
        word_addr <= word_addr + axi_sram_pkg::SRAM_ADDR_WIDTH'(1);
      end
    end
  end

  assign cmd_valid = busy;

  always_comb begin
    cmd       = '0;
    cmd.addr  = word_addr;
    cmd.wr_en = 1'b0;
    cmd.meta  = id;
    cmd.last  = (beats_left == 8'd0);
  end

  ////////////////////////////////////////
  // responses back onto r.
  ////////////////////////////////////////

  assign r_valid   = rsp_valid;
  assign rsp_ready = r_ready;

  always_comb begin
    r.id   = rsp.meta;
    r.data = rsp.data;
    r.resp = axi_sram_pkg::resp_okay;
    r.last = rsp.last;
  end

  // wrap bursts are not handled.
  a_no_wrap: assert property (@(posedge clk) disable iff (~rst_n)
    ar_fire |-> ar.burst != axi_sram_pkg::burst_wrap);

  // the arbiter may stall us, the command must not move meanwhile.
  a_cmd_stable: assert property (@(posedge clk) disable iff (~rst_n)
    cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd));

endmodule

// File: axi_sram/axi_sram_wr.sv
`timescale 1ns/10ps

module axi_sram_wr (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    aw_valid,
  output logic                    aw_ready,
  input  axi_sram_pkg::axi_ar_t   aw,
  input  logic                    w_valid,
  output logic                    w_ready,
  input  axi_sram_pkg::axi_w_t    w,
  output logic                    b_valid,
  input  logic                    b_ready,
  output axi_sram_pkg::axi_b_t    b,
  output logic                    cmd_valid,
  input  logic                    cmd_ready,
  output axi_sram_pkg::sram_cmd_t cmd
);

  typedef enum logic [1:0] {
    wr_idle,
    wr_data,
    wr_resp
  } wr_state_e;

  wr_state_e                                state;
  logic [axi_sram_pkg::SRAM_ADDR_WIDTH-1:0] word_addr;
  logic [axi_sram_pkg::ID_WIDTH-1:0]        id;
  axi_sram_pkg::axi_burst_e                 burst;
  logic [7:0]                               beats_left;
  logic                                     w_done;
  logic                                     aw_fire;
  logic                                     w_fire;
  logic                                     cmd_fire;

  assign aw_ready = (state == wr_idle);
  // take a beat only when the command slot frees up.
  assign w_ready  = (state == wr_data) && !w_done && (!cmd_valid || cmd_ready);
  assign aw_fire  = aw_valid && aw_ready;
  assign w_fire   = w_valid && w_ready;
  assign cmd_fire = cmd_valid && cmd_ready;

  ////////////////////////////////////////
  // control fsm.
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (~rst_n) begin
      state     <= wr_idle;
      cmd_valid <= 1'b0;
      w_done    <= 1'b0;
    end else begin
      case (state)
        wr_idle: begin
          if (aw_fire) begin
            state  <= wr_data;
            w_done <= 1'b0;
          end
        end
        wr_data: begin
          if (w_fire) begin
            cmd_valid <= 1'b1;
            if (beats_left == 8'd0) w_done <= 1'b1;  // all beats taken.
          end else if (cmd_fire) begin
            cmd_valid <= 1'b0;
          end
          if (cmd_fire && cmd.last) state <= wr_resp;
        end
        wr_resp: begin
          if (b_ready) state <= wr_idle;
        end
        default: state <= wr_idle;
      endcase
    end
  end

  ////////////////////////////////////////
  // burst tracking and command register.
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      word_addr  <= aw.addr[axi_sram_pkg::AXI_ADDR_WIDTH-1:axi_sram_pkg::ADDR_LSB];
      id         <= aw.id;
      burst      <= aw.burst;
      beats_left <= aw.len;
    end else if (w_fire) begin
      cmd.addr   <= word_addr;
      cmd.wr_en  <= 1'b1;
      cmd.data   <= w.data;
      cmd.strb   <= w.strb;
      cmd.meta   <= id;
      cmd.last   <= w.last;
      beats_left <= beats_left - 8'd1;
      if (burst == axi_sram_pkg::burst_incr) begin
        word_addr <= word_addr + axi_sram_pkg::SRAM_ADDR_WIDTH'(1);
      end
    end
  end

  assign b_valid = (state == wr_resp);

  always_comb begin
    b.id   = id;
    b.resp = axi_sram_pkg::resp_okay;  // no error cases.
  end

  // master's wlast must agree with the aw length.
  a_wlast_count: assert property (@(posedge clk) disable iff (~rst_n)
    w_fire |-> w.last == (beats_left == 8'd0));

  a_no_wrap: assert property (@(posedge clk) disable iff (~rst_n)
    aw_fire |-> aw.burst != axi_sram_pkg::burst_wrap);

endmodule

// File: axi_sram/sram_arbiter.sv
`timescale 1ns/10ps

module sram_arbiter (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    rd_cmd_valid,
  output logic                    rd_cmd_ready,
  input  axi_sram_pkg::sram_cmd_t rd_cmd,
  input  logic                    wr_cmd_valid,
  output logic                    wr_cmd_ready,
  input  axi_sram_pkg::sram_cmd_t wr_cmd,
  output logic                    mem_cmd_valid,
  input  logic                    mem_cmd_ready,
  output axi_sram_pkg::sram_cmd_t mem_cmd,
  input  logic                    mem_rsp_valid,
  output logic                    mem_rsp_ready,
  input  axi_sram_pkg::sram_rsp_t mem_rsp,
  output logic                    rd_rsp_valid,
  input  logic                    rd_rsp_ready,
  output axi_sram_pkg::sram_rsp_t rd_rsp
);

  logic last_wr;   // last grant went to write.
  logic hold;      // grant locked until accepted.
  logic hold_wr;
  logic grant_wr;

  always_comb begin
    if (hold) begin
      grant_wr = hold_wr;
    end else if (rd_cmd_valid && wr_cmd_valid) begin
      grant_wr = !last_wr;  // round robin.
    end else begin
      grant_wr = wr_cmd_valid;
    end
  end

  assign mem_cmd_valid = grant_wr ? wr_cmd_valid : rd_cmd_valid;
  assign mem_cmd       = grant_wr ? wr_cmd : rd_cmd;
  assign rd_cmd_ready  = !grant_wr && mem_cmd_ready;
  assign wr_cmd_ready  = grant_wr && mem_cmd_ready;

  always_ff @(posedge clk) begin
    if (~rst_n) begin
      last_wr <= 1'b0;
      hold    <= 1'b0;
      hold_wr <= 1'b0;
    end else if (mem_cmd_valid && mem_cmd_ready) begin
      last_wr <= grant_wr;
      hold    <= 1'b0;
    end else if (mem_cmd_valid) begin
      hold    <= 1'b1;
      hold_wr <= grant_wr;
    end
  end

  ////////////////////////////////////////
  // read data goes straight back.
  ////////////////////////////////////////

  assign rd_rsp_valid  = mem_rsp_valid;
  assign rd_rsp        = mem_rsp;
  assign mem_rsp_ready = rd_rsp_ready;

  // a switch of side would flip wr_en, so the stalled command must not move.
  a_grant_locked: assert property (@(posedge clk) disable iff (~rst_n)
    mem_cmd_valid && !mem_cmd_ready |=> mem_cmd_valid && $stable(mem_cmd));

endmodule

// File: rtl/axi_sram_top.sv
`timescale 1ns/10ps

module axi_sram_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ar_valid,
  output logic                  ar_ready,
  input  axi_sram_pkg::axi_ar_t ar,
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  axi_sram_pkg::axi_ar_t aw,
  input  logic                  w_valid,
  output logic                  w_ready,
  input  axi_sram_pkg::axi_w_t  w,
  output logic                  r_valid,
  input  logic                  r_ready,
  output axi_sram_pkg::axi_r_t  r,
  output logic                  b_valid,
  input  logic                  b_ready,
  output axi_sram_pkg::axi_b_t  b
);

  logic                    rd_cmd_valid, rd_cmd_ready;
  axi_sram_pkg::sram_cmd_t rd_cmd;
  logic                    wr_cmd_valid, wr_cmd_ready;
  axi_sram_pkg::sram_cmd_t wr_cmd;
  logic                    mem_cmd_valid, mem_cmd_ready;
  axi_sram_pkg::sram_cmd_t mem_cmd;
  logic                    mem_rsp_valid, mem_rsp_ready;
  axi_sram_pkg::sram_rsp_t mem_rsp;
  logic                    rd_rsp_valid, rd_rsp_ready;
  axi_sram_pkg::sram_rsp_t rd_rsp;

  axi_sram_rd i_rd (
    .clk(clk), .rst_n(rst_n),
    .ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
    .r_valid(r_valid), .r_ready(r_ready), .r(r),
    .cmd_valid(rd_cmd_valid), .cmd_ready(rd_cmd_ready), .cmd(rd_cmd),
    .rsp_valid(rd_rsp_valid), .rsp_ready(rd_rsp_ready), .rsp(rd_rsp)
  );

  axi_sram_wr i_wr (
    .clk(clk), .rst_n(rst_n),
    .aw_valid(aw_valid), .aw_ready(aw_ready), .aw(aw),
    .w_valid(w_valid), .w_ready(w_ready), .w(w),
    .b_valid(b_valid), .b_ready(b_ready), .b(b),
    .cmd_valid(wr_cmd_valid), .cmd_ready(wr_cmd_ready), .cmd(wr_cmd)
  );

  // both command streams share the one sram port.
  sram_arbiter i_arb (
    .clk(clk), .rst_n(rst_n),
    .rd_cmd_valid(rd_cmd_valid), .rd_cmd_ready(rd_cmd_ready), .rd_cmd(rd_cmd),
    .wr_cmd_valid(wr_cmd_valid), .wr_cmd_ready(wr_cmd_ready), .wr_cmd(wr_cmd),
    .mem_cmd_valid(mem_cmd_valid), .mem_cmd_ready(mem_cmd_ready), .mem_cmd(mem_cmd),
    .mem_rsp_valid(mem_rsp_valid), .mem_rsp_ready(mem_rsp_ready), .mem_rsp(mem_rsp),
    .rd_rsp_valid(rd_rsp_valid), .rd_rsp_ready(rd_rsp_ready), .rd_rsp(rd_rsp)
  );

  sram_mem i_mem (
    .clk(clk), .rst_n(rst_n),
    .cmd_valid(mem_cmd_valid), .cmd_ready(mem_cmd_ready), .cmd(mem_cmd),
    .rsp_valid(mem_rsp_valid), .rsp_ready(mem_rsp_ready), .rsp(mem_rsp)
  );

endmodule

// File: tests/axi_sram_tb_model.svh
`ifndef AXI_SRAM_TB_MODEL_SVH
`define AXI_SRAM_TB_MODEL_SVH

////////////////////////////////////////
// reference memory and expected beats.
////////////////////////////////////////

logic [axi_sram_pkg::AXI_DATA_WIDTH-1:0] model_mem [axi_sram_pkg::SRAM_DEPTH];
axi_sram_pkg::axi_r_t                    exp_q [$];  // every id, in ar issue order.

// word hit by a given beat.
function automatic logic [axi_sram_pkg::SRAM_ADDR_WIDTH-1:0] beat_word(
  input axi_sram_pkg::axi_ar_t a,
  input int                    beat
);
  logic [axi_sram_pkg::SRAM_ADDR_WIDTH-1:0] start;
  start = a.addr[axi_sram_pkg::AXI_ADDR_WIDTH-1:axi_sram_pkg::ADDR_LSB];
  if (a.burst == axi_sram_pkg::burst_fixed) begin
    return start;  // same word every beat.
  end
  return start + axi_sram_pkg::SRAM_ADDR_WIDTH'(beat);
endfunction

function automatic void model_write_beat(
  input logic [axi_sram_pkg::SRAM_ADDR_WIDTH-1:0] word,
  input logic [axi_sram_pkg::AXI_DATA_WIDTH-1:0]  data,
  input logic [axi_sram_pkg::STRB_WIDTH-1:0]      strb
);
  for (int k = 0; k < axi_sram_pkg::STRB_WIDTH; k++) begin
    if (strb[k]) model_mem[word][k*8 +: 8] = data[k*8 +: 8];
  end
endfunction

// queue up the beats a read burst should return.
function automatic void model_expect_read(input axi_sram_pkg::axi_ar_t a);
  axi_sram_pkg::axi_r_t beat;
  for (int i = 0; i <= int'(a.len); i++) begin
    beat.id   = a.id;
    beat.data = model_mem[beat_word(a, i)];
    beat.resp = axi_sram_pkg::resp_okay;
    beat.last = (i == int'(a.len));
    exp_q.push_back(beat);
  end
endfunction

`endif

// File: tests/axi_sram_tb.sv
`timescale 1ns/10ps

module axi_sram_tb;

  localparam int TXN_COUNT      = 200;
  localparam int MAX_BEATS      = 8;
  localparam int TIMEOUT_CYCLES = TXN_COUNT * MAX_BEATS * 10 + 1000;
  localparam int WIN_BASE       = 'h780;  // 128 words at the top of memory.
  localparam int HALF_WORDS     = 64;

  logic                  clk;
  logic                  rst_n;
  logic                  ar_valid, ar_ready, aw_valid, aw_ready, w_valid, w_ready;
  logic                  r_valid, r_ready, b_valid, b_ready;
  axi_sram_pkg::axi_ar_t ar, aw;
  axi_sram_pkg::axi_w_t  w;
  axi_sram_pkg::axi_r_t  r;
  axi_sram_pkg::axi_b_t  b;

  int                                data_errors   = 0;
  int                                proto_errors  = 0;
  int                                beats_checked = 0;
  int                                cycle_count   = 0;
  logic [axi_sram_pkg::ID_WIDTH-1:0] exp_bid;
  logic                              wr_pending    = 1'b0;
  logic                              w_all_sent    = 1'b0;

  `include "axi_sram_tb_model.svh"

  axi_sram_top i_dut (.*);

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    data_errors++;
  endtask

  function automatic void print_summary();
    $display("errors: %0d data, %0d protocol; %0d read beats checked",
             data_errors, proto_errors, beats_checked);
  endfunction

  // one sample point per cycle, just after the falling edge.
  task automatic next_sample();
    @(negedge clk);
    #1;
  endtask

  task automatic drain_reads();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  function automatic axi_sram_pkg::axi_ar_t pick_burst(input int half);
    axi_sram_pkg::axi_ar_t a;
    int                    span;
    int                    word;
    a.id    = axi_sram_pkg::ID_WIDTH'($urandom);
    a.len   = 8'($urandom_range(MAX_BEATS - 1));
    a.burst = ($urandom_range(3) == 0) ? axi_sram_pkg::burst_fixed
                                       : axi_sram_pkg::burst_incr;
    span    = (a.burst == axi_sram_pkg::burst_incr) ? HALF_WORDS - int'(a.len) : HALF_WORDS;
    word    = WIN_BASE + half * HALF_WORDS + int'($urandom_range(span - 1));
    a.addr  = axi_sram_pkg::AXI_ADDR_WIDTH'(word << axi_sram_pkg::ADDR_LSB);
    return a;
  endfunction

  task automatic read_burst(input axi_sram_pkg::axi_ar_t a);
    model_expect_read(a);
    @(negedge clk);
    ar       = a;
    ar_valid = 1'b1;
    #1;
    while (!ar_ready) next_sample();
    @(negedge clk);
    ar_valid = 1'b0;
  endtask

  task automatic write_burst(input axi_sram_pkg::axi_ar_t a, input logic full_strb);
    axi_sram_pkg::axi_w_t beats [MAX_BEATS];
    for (int i = 0; i <= int'(a.len); i++) begin
      beats[i].data = axi_sram_pkg::AXI_DATA_WIDTH'($urandom);
      beats[i].strb = full_strb ? {axi_sram_pkg::STRB_WIDTH{1'b1}}
                                : axi_sram_pkg::STRB_WIDTH'($urandom);
      beats[i].last = (i == int'(a.len));
      model_write_beat(beat_word(a, i), beats[i].data, beats[i].strb);
    end
    exp_bid    = a.id;
    w_all_sent = 1'b0;
    wr_pending = 1'b1;
    @(negedge clk);
    aw       = a;
    aw_valid = 1'b1;
    #1;
    while (!aw_ready) next_sample();
    @(negedge clk);
    aw_valid = 1'b0;
    for (int i = 0; i <= int'(a.len); i++) begin
      w       = beats[i];
      w_valid = 1'b1;
      #1;
      while (!w_ready) next_sample();
      @(negedge clk);
    end
    w_valid    = 1'b0;
    w_all_sent = 1'b1;
    while (wr_pending) @(negedge clk);
  endtask

  ////////////////////////////////////////
  // clock, back-pressure, watchdog.
  ////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    r_ready = 1'b0;
    b_ready = 1'b0;
    forever begin
      @(negedge clk);
      r_ready = ($urandom_range(99) >= 30);  // low about 30 percent.
      b_ready = ($urandom_range(99) >= 30);
    end
  end

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    print_summary();
    $display("Regression failed");
    $finish;
  end

  ////////////////////////////////////////
  // monitors.
  ////////////////////////////////////////

  initial begin
    axi_sram_pkg::axi_r_t want;
    forever begin
      next_sample();
      if (r_valid && r_ready) begin
        if (exp_q.size() == 0) begin
          $display("protocol error at %0t: R beat with no read outstanding", $time);
          proto_errors++;
        end else begin
          want = exp_q.pop_front();
          beats_checked++;
          if (r !== want) begin
            report_mismatch($sformatf("R id %0h data %04h resp %0d last %0b, want %0h %04h 0 %0b",
                                      r.id, r.data, r.resp, r.last,
                                      want.id, want.data, want.last));
          end
        end
      end
    end
  end

  initial begin
    forever begin
      next_sample();
      if (b_valid && b_ready) begin
        if (!wr_pending) begin
          $display("protocol error at %0t: B response with no write outstanding", $time);
          proto_errors++;
        end else begin
          if (!w_all_sent) begin
            $display("protocol error at %0t: B response before the last W beat", $time);
            proto_errors++;
          end
          if (b.id !== exp_bid || b.resp !== axi_sram_pkg::resp_okay) begin
            report_mismatch($sformatf("B id %0h resp %0d, want id %0h resp 0",
                                      b.id, b.resp, exp_bid));
          end
          wr_pending = 1'b0;
        end
      end
    end
  end

  ////////////////////////////////////////
  // stimulus.
  ////////////////////////////////////////

  initial begin
    axi_sram_pkg::axi_ar_t fill;
    axi_sram_pkg::axi_ar_t rd;
    axi_sram_pkg::axi_ar_t wr;
    int                    kind;
    int                    h;
    void'($urandom(32'h55eddcec));
    rst_n    = 1'b0;
    ar_valid = 1'b0;
    ar       = '0;
    aw_valid = 1'b0;
    aw       = '0;
    w_valid  = 1'b0;
    w        = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    if (ar_ready !== 1'b1) report_mismatch("ar_ready low after reset");
    if (aw_ready !== 1'b1) report_mismatch("aw_ready low after reset");
    if (w_ready !== 1'b0) report_mismatch("w_ready high after reset");
    if (r_valid !== 1'b0) report_mismatch("r_valid high after reset");
    if (b_valid !== 1'b0) report_mismatch("b_valid high after reset");

    // known contents for the whole window first.
    for (int blk = 0; blk < 2 * HALF_WORDS / MAX_BEATS; blk++) begin
      fill.id    = '0;
      fill.addr  = axi_sram_pkg::AXI_ADDR_WIDTH'((WIN_BASE + blk * MAX_BEATS)
                                                 << axi_sram_pkg::ADDR_LSB);
      fill.len   = 8'(MAX_BEATS - 1);
      fill.burst = axi_sram_pkg::burst_incr;
      write_burst(fill, 1'b1);
    end

    for (int n = 0; n < TXN_COUNT; n++) begin
      kind = $urandom_range(9);
      h    = $urandom_range(1);
      if (kind < 4) begin
        wr = pick_burst(h);
        drain_reads();  // no read may still touch the words.
        write_burst(wr, 1'b0);
        rd    = wr;
        rd.id = axi_sram_pkg::ID_WIDTH'($urandom);
        read_burst(rd);
      end else if (kind < 8) begin
        read_burst(pick_burst(h));  // left in flight.
      end else begin
        // read and write side by side, one half each.
        rd = pick_burst(h);
        wr = pick_burst(1 - h);
        drain_reads();
        fork
          write_burst(wr, 1'b0);
          read_burst(rd);
        join
      end
    end

    drain_reads();
    repeat (20) @(negedge clk);
    print_summary();
    if (data_errors == 0 && proto_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+tests
common/axi_sram_pkg.sv
rtl/sram_mem.sv
axi_sram/axi_sram_rd.sv
axi_sram/axi_sram_wr.sv
axi_sram/sram_arbiter.sv
rtl/axi_sram_top.sv
tests/axi_sram_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f list.f --top-module axi_sram_tb -o axi_sram_sim

status=0
./obj_dir/axi_sram_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Regression failed" sim.log; then
  exit 1
fi
grep -q "Regression passed" sim.log
